// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and pass only on the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_video_top -o tb_video_top -f tb.f

out=$(./obj_dir/tb_video_top)
echo "$out"
echo "$out" | grep -qx "No errors"

// File: src/double_frame_buffer.sv
`timescale 1ns/10ps

module double_frame_buffer #(
    parameter int FB_WIDTH  = 16,
    parameter int FB_HEIGHT = 12
) (
    input  logic                                  clk_display,
    input  logic                                  rstn_display,
    input  logic                                  wr_en,
    input  logic [$clog2(FB_WIDTH*FB_HEIGHT)-1:0] wr_addr,
    input  logic [frame_pkg::PIXEL_W-1:0]         wr_data,
    input  logic                                  frame_req,
    input  logic                                  vblank_start,
    input  logic [$clog2(FB_WIDTH*FB_HEIGHT)-1:0] rd_addr,
    output logic                                  frame_ack,
    output logic [frame_pkg::PIXEL_W-1:0]         rd_data
);
    localparam int DEPTH = FB_WIDTH * FB_HEIGHT;

    logic [frame_pkg::PIXEL_W-1:0] mem0 [DEPTH];
    logic [frame_pkg::PIXEL_W-1:0] mem1 [DEPTH];

    // Low selects mem0 for display and mem1 for drawing
    logic front_sel;
    logic swap;

    // Swap on a fresh request at the top of vertical blank
    assign swap = vblank_start && frame_req && !frame_ack;

    ////////////////////////////////////////////////////////////////////////////
    // Front/back selection and acknowledge
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            front_sel <= 1'b0;
            frame_ack <= 1'b0;
        end else begin
            if (swap) begin
                front_sel <= ~front_sel;
                frame_ack <= 1'b1;
            end else if (frame_ack && !frame_req) begin
                // Close the handshake once the drawer drops its request
                frame_ack <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pixel memories
    ////////////////////////////////////////////////////////////////////////////

    // Writes always land in the back half
    always_ff @(posedge clk_display) begin
        if (wr_en && front_sel) begin
            mem0[wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge clk_display) begin
        if (wr_en && !front_sel) begin
            mem1[wr_addr] <= wr_data;
        end
    end

    // Registered read from the front half with one cycle of latency
    always_ff @(posedge clk_display) begin
        if (front_sel) begin
            rd_data <= mem1[rd_addr];
        end else begin
            rd_data <= mem0[rd_addr];
        end
    end

endmodule

// File: src/frame_pkg.sv
package frame_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Pixel format
    ////////////////////////////////////////////////////////////////////////////

    // 4 bits each of red, green, blue; red in the top nibble
    parameter int PIXEL_W = 12;

    ////////////////////////////////////////////////////////////////////////////
    // Pattern opcodes and drawer FSM
    ////////////////////////////////////////////////////////////////////////////

    // Opcodes on pattern_sel
    typedef enum logic [1:0] {
        PAT_SOLID    = 2'd0,
        PAT_GRADIENT = 2'd1,
        PAT_CHECKER  = 2'd2
    } pattern_t;

    // Drawer states
    typedef enum logic [1:0] {
        DRAW_IDLE    = 2'd0,
        DRAW_FILL    = 2'd1,
        DRAW_REQ     = 2'd2,
        DRAW_RELEASE = 2'd3
    } draw_state_t;

endpackage

// File: src/pattern_drawer.sv
`timescale 1ns/10ps

module pattern_drawer #(
    parameter int FB_WIDTH  = 16,
    parameter int FB_HEIGHT = 12
) (
    input  logic                           clk_display,
    input  logic                           rstn_display,
    input  frame_pkg::pattern_t            pattern_sel,
    input  logic [frame_pkg::PIXEL_W-1:0]  color,
    input  logic                           frame_ack,
    output logic                           wr_en,
    output logic [$clog2(FB_WIDTH*FB_HEIGHT)-1:0] wr_addr,
    output logic [frame_pkg::PIXEL_W-1:0]  wr_data,
    output logic                           frame_req
);
    localparam int ADDR_W = $clog2(FB_WIDTH * FB_HEIGHT);
    localparam int X_W    = (FB_WIDTH > 1) ? $clog2(FB_WIDTH) : 1;
    localparam int Y_W    = (FB_HEIGHT > 1) ? $clog2(FB_HEIGHT) : 1;

    frame_pkg::draw_state_t         state;
    frame_pkg::pattern_t            pat_q;
    logic [frame_pkg::PIXEL_W-1:0]  color_q;
    logic [X_W-1:0]                 x;
    logic [Y_W-1:0]                 y;
    logic [ADDR_W-1:0]              addr;
    logic                           last_col;
    logic                           last_pixel;

    assign last_col   = (x == X_W'(FB_WIDTH - 1));
    assign last_pixel = last_col && (y == Y_W'(FB_HEIGHT - 1));

    ////////////////////////////////////////////////////////////////////////////
    // FSM: fill, then four-phase req/ack with the buffer
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            state <= frame_pkg::DRAW_IDLE;
        end else begin
            case (state)
                frame_pkg::DRAW_IDLE:    state <= frame_pkg::DRAW_FILL;
                frame_pkg::DRAW_FILL:    if (last_pixel) state <= frame_pkg::DRAW_REQ;
                frame_pkg::DRAW_REQ:     if (frame_ack) state <= frame_pkg::DRAW_RELEASE;
                frame_pkg::DRAW_RELEASE: if (!frame_ack) state <= frame_pkg::DRAW_IDLE;
                default:                 state <= frame_pkg::DRAW_IDLE;
            endcase
        end
    end

    // Raster walk over the back buffer, one pixel per cycle
    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            x    <= '0;
            y    <= '0;
            addr <= '0;
        end else if (state == frame_pkg::DRAW_IDLE) begin
            x    <= '0;
            y    <= '0;
            addr <= '0;
        end else if (state == frame_pkg::DRAW_FILL) begin
            addr <= addr + 1'b1;
            if (last_col) begin
                x <= '0;
                y <= y + 1'b1;
            end else begin
                x <= x + 1'b1;
            end
        end
    end

    // Pattern and color held for the whole fill
    always_ff @(posedge clk_display) begin
        if (state == frame_pkg::DRAW_IDLE) begin
            pat_q   <= pattern_sel;
            color_q <= color;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pixel rules
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (pat_q)
            frame_pkg::PAT_SOLID:    wr_data = color_q;
            frame_pkg::PAT_GRADIENT: wr_data = {4'(x), 4'(y), color_q[3:0]};
            frame_pkg::PAT_CHECKER:  wr_data = (x[0] ^ y[0]) ? color_q : '0;
            default:                 wr_data = '0;
        endcase
    end

    assign wr_en     = (state == frame_pkg::DRAW_FILL);
    assign wr_addr   = addr;
    assign frame_req = (state == frame_pkg::DRAW_REQ);

endmodule

// File: src/raster_scanner.sv
`timescale 1ns/10ps

module raster_scanner #(
    parameter int H_ACTIVE = 16,
    parameter int H_FRONT  = 2,
    parameter int H_SYNC   = 2,
    parameter int H_BACK   = 4,
    parameter int V_ACTIVE = 12,
    parameter int V_FRONT  = 1,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 2,
    parameter bit SYNC_POL = 1'b0
) (
    input  logic                                 clk_display,
    input  logic                                 rstn_display,
    input  logic [frame_pkg::PIXEL_W-1:0]        rd_data,
    output logic [$clog2(H_ACTIVE*V_ACTIVE)-1:0] rd_addr,
    output logic                                 vblank_start,
    output logic                                 vga_hsync,
    output logic                                 vga_vsync,
    output logic                                 vga_de,
    output logic [frame_pkg::PIXEL_W-1:0]        vga_rgb
);
    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int HW      = $clog2(H_TOTAL);
    localparam int VW      = $clog2(V_TOTAL);
    localparam int ADDR_W  = $clog2(H_ACTIVE * V_ACTIVE);

    logic [HW-1:0]          h_cnt;
    logic [VW-1:0]          v_cnt;
    video_pkg::scan_state_t h_state;
    video_pkg::scan_state_t v_state;
    logic                   de_now;

    // Phase of one axis from its counter and segment lengths
    function automatic video_pkg::scan_state_t phase_of(input int cnt, input int act,
                                                        input int front, input int sync);
        if (cnt < act) begin
            return video_pkg::SCAN_ACTIVE;
        end else if (cnt < act + front) begin
            return video_pkg::SCAN_FRONT;
        end else if (cnt < act + front + sync) begin
            return video_pkg::SCAN_SYNC;
        end
        return video_pkg::SCAN_BACK;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Counters
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == HW'(H_TOTAL - 1)) begin
            h_cnt <= '0;
            if (v_cnt == VW'(V_TOTAL - 1)) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    assign h_state = phase_of(int'(h_cnt), H_ACTIVE, H_FRONT, H_SYNC);
    assign v_state = phase_of(int'(v_cnt), V_ACTIVE, V_FRONT, V_SYNC);
    assign de_now  = (h_state == video_pkg::SCAN_ACTIVE) && (v_state == video_pkg::SCAN_ACTIVE);

    // First clock of the vertical front porch
    assign vblank_start = (h_cnt == '0) && (v_cnt == VW'(V_ACTIVE));

    // Linear front-buffer index, y * width + x
    assign rd_addr = de_now ? ADDR_W'(int'(v_cnt) * H_ACTIVE + int'(h_cnt)) : '0;

    ////////////////////////////////////////////////////////////////////////////
    // Outputs, one cycle behind the counters to meet rd_data
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            vga_hsync <= ~SYNC_POL;
            vga_vsync <= ~SYNC_POL;
            vga_de    <= 1'b0;
        end else begin
            vga_hsync <= (h_state == video_pkg::SCAN_SYNC) ^ ~SYNC_POL;
            vga_vsync <= (v_state == video_pkg::SCAN_SYNC) ^ ~SYNC_POL;
            vga_de    <= de_now;
        end
    end

    // Black outside the active area
    assign vga_rgb = vga_de ? rd_data : '0;

endmodule

// File: src/video_pkg.sv
package video_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Default raster timing
    ////////////////////////////////////////////////////////////////////////////

    // Horizontal, in pixel clocks
    parameter int H_ACTIVE = 16;
    parameter int H_FRONT  = 2;
    parameter int H_SYNC   = 2;
    parameter int H_BACK   = 4;

    // Vertical, in lines
    parameter int V_ACTIVE = 12;
    parameter int V_FRONT  = 1;
    parameter int V_SYNC   = 2;
    parameter int V_BACK   = 2;

    // 0 gives active-low sync pulses
    parameter bit SYNC_POL = 1'b0;

    // Totals
    parameter int H_TOTAL    = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    parameter int V_TOTAL    = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    parameter int FRAME_CLKS = H_TOTAL * V_TOTAL;

    // Phase of one scan axis
    typedef enum logic [1:0] {
        SCAN_ACTIVE = 2'd0,
        SCAN_FRONT  = 2'd1,
        SCAN_SYNC   = 2'd2,
        SCAN_BACK   = 2'd3
    } scan_state_t;

endpackage

// File: src/video_top.sv
`timescale 1ns/10ps

module video_top #(
    parameter int H_ACTIVE = video_pkg::H_ACTIVE,
    parameter int H_FRONT  = video_pkg::H_FRONT,
    parameter int H_SYNC   = video_pkg::H_SYNC,
    parameter int H_BACK   = video_pkg::H_BACK,
    parameter int V_ACTIVE = video_pkg::V_ACTIVE,
    parameter int V_FRONT  = video_pkg::V_FRONT,
    parameter int V_SYNC   = video_pkg::V_SYNC,
    parameter int V_BACK   = video_pkg::V_BACK,
    parameter bit SYNC_POL = video_pkg::SYNC_POL
) (
    input  logic                          clk_display,
    input  logic                          rstn_display,
    input  frame_pkg::pattern_t           pattern_sel,
    input  logic [frame_pkg::PIXEL_W-1:0] color,
    output logic                          vga_hsync,
    output logic                          vga_vsync,
    output logic                          vga_de,
    output logic [frame_pkg::PIXEL_W-1:0] vga_rgb
);
    // Buffer covers exactly the active area
    localparam int FB_WIDTH  = H_ACTIVE;
    localparam int FB_HEIGHT = V_ACTIVE;
    localparam int ADDR_W    = $clog2(FB_WIDTH * FB_HEIGHT);

    // Drawer to buffer
    logic                          wr_en;
    logic [ADDR_W-1:0]             wr_addr;
    logic [frame_pkg::PIXEL_W-1:0] wr_data;
    logic                          frame_req;
    logic                          frame_ack;

    // Scanner to buffer and back
    logic                          vblank_start;
    logic [ADDR_W-1:0]             rd_addr;
    logic [frame_pkg::PIXEL_W-1:0] rd_data;

    ////////////////////////////////////////////////////////////////////////////
    // Producer, buffer, consumer
    ////////////////////////////////////////////////////////////////////////////

    pattern_drawer #(
        .FB_WIDTH  (FB_WIDTH),
        .FB_HEIGHT (FB_HEIGHT)
    ) u_drawer (
        .clk_display  (clk_display),
        .rstn_display (rstn_display),
        .pattern_sel  (pattern_sel),
        .color        (color),
        .frame_ack    (frame_ack),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .frame_req    (frame_req)
    );

    double_frame_buffer #(
        .FB_WIDTH  (FB_WIDTH),
        .FB_HEIGHT (FB_HEIGHT)
    ) u_buffer (
        .clk_display  (clk_display),
        .rstn_display (rstn_display),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .frame_req    (frame_req),
        .vblank_start (vblank_start),
        .rd_addr      (rd_addr),
        .frame_ack    (frame_ack),
        .rd_data      (rd_data)
    );

    raster_scanner #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK),
        .SYNC_POL (SYNC_POL)
    ) u_scanner (
        .clk_display  (clk_display),
        .rstn_display (rstn_display),
        .rd_data      (rd_data),
        .rd_addr      (rd_addr),
        .vblank_start (vblank_start),
        .vga_hsync    (vga_hsync),
        .vga_vsync    (vga_vsync),
        .vga_de       (vga_de),
        .vga_rgb      (vga_rgb)
    );

endmodule

// File: tb.f
src/video_pkg.sv
src/frame_pkg.sv
src/pattern_drawer.sv
src/double_frame_buffer.sv
src/raster_scanner.sv
src/video_top.sv
tb/clock_gen.sv
tb/tb_video_top.sv

// File: tb/clock_gen.sv
`timescale 1ns/10ps

module clock_gen (
    output logic clk_display,
    output logic rstn_display
);
    // 4 ns period, reset released just after the fifth rising edge
    initial begin
        clk_display  = 1'b0;
        rstn_display = 1'b0;
        repeat (5) @(posedge clk_display);
        #1;
        rstn_display = 1'b1;
    end

    always #2 clk_display = ~clk_display;

endmodule

// File: tb/tb_video_top.sv
`timescale 1ns/10ps

module tb_video_top;
    localparam int FB_W        = video_pkg::H_ACTIVE;
    localparam int FB_PIXELS   = video_pkg::H_ACTIVE * video_pkg::V_ACTIVE;
    localparam int PW          = frame_pkg::PIXEL_W;
    localparam int NUM_TESTS   = 6;
    localparam int WATCHDOG_NS = NUM_TESTS * 6 * video_pkg::FRAME_CLKS * 4;

    logic                clk_display;
    logic                rstn_display;
    frame_pkg::pattern_t pattern_sel;
    logic [PW-1:0]       color;
    logic                vga_hsync;
    logic                vga_vsync;
    logic                vga_de;
    logic [PW-1:0]       vga_rgb;

    int                  errors = 0;
    int                  checks = 0;
    integer              seed;
    frame_pkg::pattern_t cur_pat;
    logic [PW-1:0]       cur_col;

    // Frame capture, x and y come from the pixel index after vsync
    logic [PW-1:0] cap_frame  [FB_PIXELS];
    logic [PW-1:0] last_frame [FB_PIXELS];
    int            pix_idx   = 0;
    int            frame_cnt = 0;
    int            start_cnt = 0;
    logic          vsync_q   = 1'b1;
    logic          capturing = 1'b0;

    clock_gen u_clock_gen (
        .clk_display  (clk_display),
        .rstn_display (rstn_display)
    );

    video_top dut (
        .clk_display  (clk_display),
        .rstn_display (rstn_display),
        .pattern_sel  (pattern_sel),
        .color        (color),
        .vga_hsync    (vga_hsync),
        .vga_vsync    (vga_vsync),
        .vga_de       (vga_de),
        .vga_rgb      (vga_rgb)
    );

    always @(negedge clk_display) begin
        if (vsync_q && !vga_vsync) begin
            pix_idx   = 0;
            capturing = 1'b1;
            start_cnt++;
        end else if (capturing && vga_de && pix_idx < FB_PIXELS) begin
            cap_frame[pix_idx] = vga_rgb;
            pix_idx++;
            if (pix_idx == FB_PIXELS) begin
                last_frame = cap_frame;
                frame_cnt++;
            end
        end
        vsync_q = vga_vsync;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model and helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [PW-1:0] expected_pixel(input frame_pkg::pattern_t pat,
                                                     input logic [PW-1:0] col,
                                                     input int x, input int y);
        case (pat)
            frame_pkg::PAT_SOLID:    return col;
            frame_pkg::PAT_GRADIENT: return {4'(x % 16), 4'(y % 16), col[3:0]};
            frame_pkg::PAT_CHECKER:  return ((x + y) % 2 == 1) ? col : '0;
            default:                 return '0;
        endcase
    endfunction

    function automatic bit frame_matches(input frame_pkg::pattern_t pat,
                                         input logic [PW-1:0] col);
        bit ok;
        int i;
        ok = 1'b1;
        for (i = 0; i < FB_PIXELS; i++) begin
            ok = ok && (last_frame[i] === expected_pixel(pat, col, i % FB_W, i / FB_W));
        end
        return ok;
    endfunction

    task automatic expect_eq(input string test, input string what,
                             input int expected, input int actual);
        checks++;
        assert (expected == actual) else begin
            errors++;
            $display("ERR %s: %s expected %0h actual %0h", test, what, expected, actual);
        end
    endtask

    task automatic drive_pattern(input frame_pkg::pattern_t pat, input logic [PW-1:0] col);
        @(posedge clk_display);
        #1;
        pattern_sel = pat;
        color       = col;
        cur_pat     = pat;
        cur_col     = col;
    endtask

    task automatic wait_frame_start();
        int start;
        start = start_cnt;
        while (start_cnt == start) begin
            @(negedge clk_display);
        end
    endtask

    task automatic wait_frames(input int n);
        int target;
        target = frame_cnt + n;
        while (frame_cnt < target) begin
            @(negedge clk_display);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    // Idle outputs during reset and just before the first active edge
    task automatic reset_outputs();
        do begin
            @(negedge clk_display);
            expect_eq("reset", "vga_de", 0, int'(vga_de));
            expect_eq("reset", "vga_rgb", 0, int'(vga_rgb));
            expect_eq("reset", "vga_hsync", 1, int'(vga_hsync));
            expect_eq("reset", "vga_vsync", 1, int'(vga_vsync));
        end while (!rstn_display);
    endtask

    task automatic raster_timing();
        logic prev_vs;
        int   line;
        int   cyc;
        int   hs_low;
        int   vs_low;
        int   de_high;
        int   de_lines;
        int   vs_lines;
        de_lines = 0;
        vs_lines = 0;
        // Line windows start at the vsync falling edge
        do begin
            prev_vs = vga_vsync;
            @(negedge clk_display);
        end while (!(prev_vs && !vga_vsync));
        for (line = 0; line < video_pkg::V_TOTAL; line++) begin
            hs_low  = 0;
            vs_low  = 0;
            de_high = 0;
            for (cyc = 0; cyc < video_pkg::H_TOTAL; cyc++) begin
                hs_low  += int'(!vga_hsync);
                vs_low  += int'(!vga_vsync);
                de_high += int'(vga_de);
                @(negedge clk_display);
            end
            expect_eq("raster_timing", $sformatf("hsync low cycles in line %0d", line),
                      video_pkg::H_SYNC, hs_low);
            de_lines += int'(de_high == video_pkg::H_ACTIVE);
            vs_lines += int'(vs_low == video_pkg::H_TOTAL);
            if (de_high != video_pkg::H_ACTIVE) begin
                expect_eq("raster_timing", "vga_de cycles in blank line", 0, de_high);
            end
        end
        expect_eq("raster_timing", "lines with vga_de", video_pkg::V_ACTIVE, de_lines);
        expect_eq("raster_timing", "lines with vsync low", video_pkg::V_SYNC, vs_lines);
    endtask

    // Solid, gradient and checker share one flow
    task automatic static_pattern(input string name, input frame_pkg::pattern_t pat);
        logic [PW-1:0] col;
        int            i;
        col = PW'($random(seed));
        drive_pattern(pat, col);
        // Third full frame after the change carries the new pattern
        wait_frame_start();
        wait_frames(3);
        for (i = 0; i < FB_PIXELS; i++) begin
            expect_eq(name, $sformatf("pixel x=%0d y=%0d", i % FB_W, i / FB_W),
                      int'(expected_pixel(pat, col, i % FB_W, i / FB_W)),
                      int'(last_frame[i]));
        end
    endtask

    task automatic tear_free_swap();
        frame_pkg::pattern_t old_pat;
        frame_pkg::pattern_t new_pat;
        logic [PW-1:0]       old_col;
        logic [PW-1:0]       new_col;
        int                  sw;
        int                  fr;
        int                  offset;
        bit                  m_old;
        bit                  m_new;
        bit                  seen_new;
        for (sw = 0; sw < 3; sw++) begin
            old_pat = cur_pat;
            old_col = cur_col;
            case (old_pat)
                frame_pkg::PAT_SOLID:    new_pat = frame_pkg::PAT_GRADIENT;
                frame_pkg::PAT_GRADIENT: new_pat = frame_pkg::PAT_CHECKER;
                default:                 new_pat = frame_pkg::PAT_SOLID;
            endcase
            new_col  = PW'($random(seed));
            offset   = int'($unsigned($random(seed)) % video_pkg::FRAME_CLKS);
            seen_new = 1'b0;
            // Switch at a varying point inside the frame
            wait_frame_start();
            repeat (offset) @(posedge clk_display);
            drive_pattern(new_pat, new_col);
            wait_frame_start();
            for (fr = 0; fr < 3; fr++) begin
                wait_frames(1);
                m_old = frame_matches(old_pat, old_col);
                m_new = frame_matches(new_pat, new_col);
                checks++;
                assert ((m_old ^ m_new) && !(seen_new && m_old)) else begin
                    errors++;
                    $display("Tear-free swap: frame %0d after switch %0d to %s is torn or stale",
                             fr, sw, new_pat.name());
                end
                seen_new = seen_new | m_new;
            end
            checks++;
            assert (seen_new) else begin
                errors++;
                $display("Tear-free swap: %s never shown within 3 frames of switch %0d",
                         new_pat.name(), sw);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        seed        = 32'h84e20ecb;
        pattern_sel = frame_pkg::PAT_SOLID;
        color       = '0;
        cur_pat     = frame_pkg::PAT_SOLID;
        cur_col     = '0;
        reset_outputs();
        raster_timing();
        static_pattern("solid", frame_pkg::PAT_SOLID);
        static_pattern("gradient", frame_pkg::PAT_GRADIENT);
        static_pattern("checker", frame_pkg::PAT_CHECKER);
        tear_free_swap();
        $display("Summary: %0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: tests still running after %0d ns", WATCHDOG_NS);
        $display("Summary: %0d errors in %0d checks", errors, checks);
        $display("Errors found");
        $finish;
    end

endmodule
